/* project.f */
logic/cpuPkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/aluUnit.sv
logic/writeBack.sv
logic/execCore.sv
verif/execCore_assert.sv
verif/execCoreTb.sv

/* verif/execCoreTb.sv */
// Testbench for the execute slice driving random instructions checked against a register model
`timescale 1ns/10ps

module execCoreTb import cpuPkg::*; ();

  localparam int clkPeriod     = 20;
  localparam int resetCycles   = 16;
  localparam int numInstr      = 2000;
  localparam int directedCount = 31; // MOV sweep plus LDI preload
  localparam int drainCycles   = 8;
  localparam int timeoutCycles = numInstr * 3 + resetCycles + drainCycles;

  logic                   clk;
  logic                   rst;
  logic                   instrValid;
  logic [15:0]            instr;
  logic                   resultValid;
  logic [regIdxWidth-1:0] resultReg;
  logic [dataWidth-1:0]   resultData;
  logic                   zeroFlag;
  logic                   negFlag;

  logic [31:0]            lcgState = 32'd29896;
  logic [dataWidth-1:0]   modelRegs [numRegs];
  logic                   modelWrote;
  logic [regIdxWidth-1:0] heldReg;   // Result ports as the model expects them
  logic [dataWidth-1:0]   heldData;
  logic                   heldZero;
  logic                   heldNeg;

  // Expected outputs, two negedges deep to match the two-edge latency
  logic                   pipeStrobe [2];
  logic                   pipeValid  [2];
  logic [regIdxWidth-1:0] pipeReg    [2];
  logic [dataWidth-1:0]   pipeData   [2];
  logic                   pipeZero   [2];
  logic                   pipeNeg    [2];

  int errorCount   = 0;
  int checkedCount = 0;

  execCore dut_i (
    .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
    .resultValid(resultValid), .resultReg(resultReg), .resultData(resultData),
    .zeroFlag(zeroFlag), .negFlag(negFlag)
  );

  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  // LCG, upper bits only
  function automatic int randRange(input int n);
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return int'(lcgState[30:16]) % n;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Finished with errors");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic resetModel();
    for (int i = 0; i < numRegs; i++) begin
      modelRegs[i] = (i == int'(spReg)) ? spResetValue : '0;
    end
    heldReg    = '0;
    heldData   = '0;
    heldZero   = 1'b0;
    heldNeg    = 1'b0;
    modelWrote = 1'b0;
  endtask

  // Reference behavior straight from the opcode table
  task automatic applyInstr(input logic [15:0] word);
    logic [3:0]             op;
    logic [dataWidth-1:0]   a;
    logic [dataWidth-1:0]   b;
    logic [dataWidth-1:0]   res;
    logic [regIdxWidth-1:0] dest;
    logic                   writes;
    op     = word[15:12];
    dest   = word[11:8];
    a      = modelRegs[word[7:4]];
    b      = modelRegs[word[3:0]];
    res    = '0;
    writes = 1'b1;
    case (op)
      OP_ADD:   res = a + b;
      OP_SUB:   res = a - b;
      OP_AND:   res = a & b;
      OP_OR:    res = a | b;
      OP_XOR:   res = a ^ b;
      OP_SHL:   res = a << b[3:0];
      OP_SHR:   res = a >> b[3:0];
      OP_MOV:   res = a;
      OP_LDI:   res = {8'h00, word[7:0]};
      OP_DSADD: res = modelRegs[dsReg] + b; // rs1 ignored
      OP_CALL: begin
        res  = modelRegs[spReg] - 16'd1;
        dest = spReg;
      end
      default:  writes = 1'b0; // NOP and unused codes
    endcase
    modelWrote = writes;
    if (writes) begin
      modelRegs[dest] = res;
      heldReg  = dest;
      heldData = res;
      heldZero = (res == '0);
      heldNeg  = res[dataWidth-1];
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      checkValue("resultValid", resultValid, pipeValid[1]);
      checkValue("resultReg", resultReg, pipeReg[1]);
      checkValue("resultData", resultData, pipeData[1]);
      checkValue("zeroFlag", zeroFlag, pipeZero[1]);
      checkValue("negFlag", negFlag, pipeNeg[1]);
      if (pipeStrobe[1]) begin
        checkedCount++;
      end
    end
    pipeStrobe[1] = pipeStrobe[0];
    pipeValid[1]  = pipeValid[0];
    pipeReg[1]    = pipeReg[0];
    pipeData[1]   = pipeData[0];
    pipeZero[1]   = pipeZero[0];
    pipeNeg[1]    = pipeNeg[0];
    modelWrote = 1'b0;
    if (rst) begin
      resetModel();
    end else if (instrValid) begin
      applyInstr(instr); // Sampled at the coming rising edge
    end
    pipeStrobe[0] = !rst && instrValid;
    pipeValid[0]  = modelWrote;
    pipeReg[0]    = heldReg;
    pipeData[0]   = heldData;
    pipeZero[0]   = heldZero;
    pipeNeg[0]    = heldNeg;
  end

  task automatic sendInstr(input logic [15:0] word, input int gap);
    @(posedge clk);
    instrValid <= 1'b1;
    instr      <= word;
    repeat (gap) begin
      @(posedge clk);
      instrValid <= 1'b0;
    end
  endtask

  initial begin
    logic [3:0] op;
    logic [3:0] rd;
    logic [3:0] rs1;
    logic [3:0] rs2;
    logic [3:0] lastRd;
    rst        = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    lastRd     = '0;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;
    // Read every register right after reset
    for (int r = 0; r < numRegs; r++) begin
      sendInstr({OP_MOV, 4'(r), 4'(r), 4'd0}, 0);
    end
    // Preload registers 0 to 14 with random immediates
    for (int r = 0; r < numRegs - 1; r++) begin
      sendInstr({OP_LDI, 4'(r), 8'(randRange(256))}, randRange(2));
    end
    for (int n = 0; n < numInstr - directedCount; n++) begin
      op  = 4'(randRange(16));
      rd  = 4'(randRange(16));
      rs1 = (randRange(4) == 0) ? lastRd : 4'(randRange(16)); // Often reuse last result
      rs2 = 4'(randRange(16));
      sendInstr({op, rd, rs1, rs2}, randRange(3));
      lastRd = (op == OP_CALL) ? spReg : rd;
    end
    @(posedge clk);
    instrValid <= 1'b0;
    repeat (drainCycles) @(posedge clk);
    checkValue("strobes checked", checkedCount, numInstr);
    if (errorCount == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "Checks failed");
    end
  end

  initial begin
    #(timeoutCycles * clkPeriod);
    $display("Timeout: the run did not finish within %0d clock cycles", timeoutCycles);
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* verif/execCore_assert.sv */
// Concurrent checks on the execute slice handshake-free timing, bound into the top level
`timescale 1ns/10ps

module execCoreAssert (
  input logic clk,
  input logic rst,
  input logic instrValid,
  input logic regWrite,
  input logic resultValid
);

  // A result pulse always traces back to a strobe two edges earlier
  resultNeedsStrobe: assert property (
    @(posedge clk) disable iff (rst) resultValid |-> $past(instrValid, 2)
  ) else $error("resultValid without a strobe two edges earlier");

  // Register writes only in the decoded cycle, one edge after the strobe
  writeNeedsStrobe: assert property (
    @(posedge clk) disable iff (rst) regWrite |-> $past(instrValid)
  ) else $error("regWrite without a strobe one edge earlier");

  resultLowInReset: assert property (
    @(posedge clk) rst && $past(rst) |-> !resultValid
  ) else $error("resultValid high during reset");

endmodule

bind execCore execCoreAssert uAssert (
  .clk(clk),
  .rst(rst),
  .instrValid(instrValid),
  .regWrite(regWrite),
  .resultValid(resultValid)
);

/* logic/execCore.sv */
// Execute slice top level joining decoder, register file, ALU and write-back
`timescale 1ns/10ps

module execCore import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instrValid,
  input  logic [15:0]            instr,
  output logic                   resultValid,
  output logic [regIdxWidth-1:0] resultReg,
  output logic [dataWidth-1:0]   resultData,
  output logic                   zeroFlag,
  output logic                   negFlag
);

  // Decoder outputs
  logic                   decValid;
  opcodeT                 aluOp;
  logic [7:0]             imm;
  logic [regIdxWidth-1:0] readReg1;
  logic [regIdxWidth-1:0] readReg2;
  logic                   dataReg;
  logic                   call;
  logic                   decWrite;
  logic [regIdxWidth-1:0] decDest;

  // Register file and ALU buses
  logic [dataWidth-1:0]   readBus1;
  logic [dataWidth-1:0]   readBus2;
  logic [dataWidth-1:0]   aluResult;
  logic                   aluZero;
  logic                   aluNeg;

  // Write port
  logic                   regWrite;
  logic [regIdxWidth-1:0] writeReg;
  logic [dataWidth-1:0]   writeBus;

  instrDecode uDecode (
    .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
    .decValid(decValid), .aluOp(aluOp), .imm(imm),
    .readReg1(readReg1), .readReg2(readReg2), .dataReg(dataReg), .call(call),
    .decWrite(decWrite), .decDest(decDest)
  );

  regFile uRegs (
    .clk(clk), .rst(rst), .dataReg(dataReg), .call(call),
    .readReg1(readReg1), .readReg2(readReg2),
    .regWrite(regWrite), .writeReg(writeReg), .writeBus(writeBus),
    .readBus1(readBus1), .readBus2(readBus2)
  );

  aluUnit uAlu (
    .aluOp(aluOp), .imm(imm), .readBus1(readBus1), .readBus2(readBus2),
    .aluResult(aluResult), .aluZero(aluZero), .aluNeg(aluNeg)
  );

  writeBack uWb (
    .clk(clk), .rst(rst), .decValid(decValid), .decWrite(decWrite), .decDest(decDest),
    .aluResult(aluResult), .aluZero(aluZero), .aluNeg(aluNeg),
    .regWrite(regWrite), .writeReg(writeReg), .writeBus(writeBus),
    .resultValid(resultValid), .resultReg(resultReg), .resultData(resultData),
    .zeroFlag(zeroFlag), .negFlag(negFlag)
  );

endmodule

/* logic/writeBack.sv */
// Write-back stage that drives the register write and holds the result ports and flags
`timescale 1ns/10ps

module writeBack import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   decValid,
  input  logic                   decWrite,
  input  logic [regIdxWidth-1:0] decDest,
  input  logic [dataWidth-1:0]   aluResult,
  input  logic                   aluZero,
  input  logic                   aluNeg,
  output logic                   regWrite,
  output logic [regIdxWidth-1:0] writeReg,
  output logic [dataWidth-1:0]   writeBus,
  output logic                   resultValid,
  output logic [regIdxWidth-1:0] resultReg,
  output logic [dataWidth-1:0]   resultData,
  output logic                   zeroFlag,
  output logic                   negFlag
);

  // Register file write happens on the same edge as the result capture
  assign regWrite = decValid & decWrite;
  assign writeReg = decDest;
  assign writeBus = aluResult;

  always_ff @(posedge clk) begin
    if (rst) begin
      resultValid <= 1'b0;
      resultReg   <= '0;
      resultData  <= '0;
      zeroFlag    <= 1'b0;
      negFlag     <= 1'b0;
    end else begin
      resultValid <= regWrite; // One-cycle pulse
      if (regWrite) begin
        resultReg  <= decDest;
        resultData <= aluResult;
        zeroFlag   <= aluZero;
        negFlag    <= aluNeg;
      end
    end
  end

endmodule

/* logic/aluUnit.sv */
// Combinational ALU for the execute slice with zero and negative result flags
`timescale 1ns/10ps

module aluUnit import cpuPkg::*; (
  input  opcodeT               aluOp,
  input  logic [7:0]           imm,
  input  logic [dataWidth-1:0] readBus1,
  input  logic [dataWidth-1:0] readBus2,
  output logic [dataWidth-1:0] aluResult,
  output logic                 aluZero,
  output logic                 aluNeg
);

  logic [3:0] shiftAmt;

  assign shiftAmt = readBus2[3:0]; // Only the low nibble counts

  always_comb begin
    case (aluOp)
      OP_ADD:   aluResult = readBus1 + readBus2; // Wraps at 16 bits
      OP_SUB:   aluResult = readBus1 - readBus2;
      OP_AND:   aluResult = readBus1 & readBus2;
      OP_OR:    aluResult = readBus1 | readBus2;
      OP_XOR:   aluResult = readBus1 ^ readBus2;
      OP_SHL:   aluResult = readBus1 << shiftAmt;
      OP_SHR:   aluResult = readBus1 >> shiftAmt; // Logical, zero fill
      OP_MOV:   aluResult = readBus1;
      OP_LDI:   aluResult = {{(dataWidth-8){1'b0}}, imm};
      // Port 1 already carries the data segment here
      OP_DSADD: aluResult = readBus1 + readBus2;
      // Port 1 carries the stack pointer
      OP_CALL:  aluResult = readBus1 - 1'b1;
      default:  aluResult = '0;
    endcase
  end

  assign aluZero = (aluResult == '0);
  assign aluNeg  = aluResult[dataWidth-1]; // Sign bit

endmodule

/* logic/regFile.sv */
// Sixteen-entry register file with two read ports, special-register steering and one write port
`timescale 1ns/10ps

module regFile import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   dataReg,   // Port 1 reads the data segment
  input  logic                   call,      // Port 1 reads the stack pointer
  input  logic [regIdxWidth-1:0] readReg1,
  input  logic [regIdxWidth-1:0] readReg2,
  input  logic                   regWrite,
  input  logic [regIdxWidth-1:0] writeReg,
  input  logic [dataWidth-1:0]   writeBus,
  output logic [dataWidth-1:0]   readBus1,
  output logic [dataWidth-1:0]   readBus2
);

  logic [dataWidth-1:0] regs [numRegs];

  // Registers 0 to 14 clear, the stack pointer starts at the top
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < numRegs; i++) begin
        if (i == int'(spReg)) begin
          regs[i] <= spResetValue;
        end else begin
          regs[i] <= '0;
        end
      end
    end else if (regWrite) begin
      regs[writeReg] <= writeBus;
    end
  end

  // Read port 1 with special-register override
  always_comb begin
    if (dataReg) begin
      readBus1 = regs[dsReg];
    end else if (call) begin
      readBus1 = regs[spReg];
    end else begin
      readBus1 = regs[readReg1];
    end
  end

  assign readBus2 = regs[readReg2]; // No steering on port 2

endmodule

/* logic/instrDecode.sv */
// Instruction decoder that captures a strobed instruction and splits it into control fields
`timescale 1ns/10ps

module instrDecode import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instrValid, // One-cycle strobe
  input  logic [15:0]            instr,
  output logic                   decValid,   // High for the cycle after the strobe
  output opcodeT                 aluOp,
  output logic [7:0]             imm,
  output logic [regIdxWidth-1:0] readReg1,
  output logic [regIdxWidth-1:0] readReg2,
  output logic                   dataReg,    // Steer port 1 to the data segment
  output logic                   call,       // Steer port 1 to the stack pointer
  output logic                   decWrite,
  output logic [regIdxWidth-1:0] decDest
);

  logic [15:0]            instrReg;
  logic [3:0]             opField;
  logic [regIdxWidth-1:0] rdField;

  // Instruction register, loaded only on the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      instrReg <= '0; // Decodes as NOP
      decValid <= 1'b0;
    end else begin
      decValid <= instrValid;
      if (instrValid) begin
        instrReg <= instr;
      end
    end
  end

  assign opField  = instrReg[15:12];
  assign rdField  = instrReg[11:8];
  assign readReg1 = instrReg[7:4];
  assign readReg2 = instrReg[3:0];
  assign imm      = instrReg[7:0];

  // Map the raw opcode field, unused codes fall back to NOP
  always_comb begin
    case (opField)
      4'd1:    aluOp = OP_ADD;
      4'd2:    aluOp = OP_SUB;
      4'd3:    aluOp = OP_AND;
      4'd4:    aluOp = OP_OR;
      4'd5:    aluOp = OP_XOR;
      4'd6:    aluOp = OP_SHL;
      4'd7:    aluOp = OP_SHR;
      4'd8:    aluOp = OP_MOV;
      4'd9:    aluOp = OP_LDI;
      4'd10:   aluOp = OP_DSADD;
      4'd11:   aluOp = OP_CALL;
      default: aluOp = OP_NOP;
    endcase
  end

  assign dataReg  = (aluOp == OP_DSADD);
  assign call     = (aluOp == OP_CALL);
  assign decWrite = (aluOp != OP_NOP); // Everything but NOP writes back

  // CALL always lands in the stack pointer
  assign decDest = call ? spReg : rdField;

endmodule

/* logic/cpuPkg.sv */
// Execute slice package with data widths, special register indices and the opcode set
package cpuPkg;

  // Data path and register file geometry
  localparam int dataWidth   = 16;
  localparam int regIdxWidth = 4;
  localparam int numRegs     = 16;

  // Special registers at the top of the file
  localparam logic [regIdxWidth-1:0] dsReg = 4'd14; // Data segment
  localparam logic [regIdxWidth-1:0] spReg = 4'd15; // Stack pointer

  // Stack grows down from the top of memory
  localparam logic [dataWidth-1:0] spResetValue = '1;

  // Operation codes, the top nibble of the instruction
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_AND   = 4'd3,
    OP_OR    = 4'd4,
    OP_XOR   = 4'd5,
    OP_SHL   = 4'd6,
    OP_SHR   = 4'd7,
    OP_MOV   = 4'd8,
    OP_LDI   = 4'd9,
    OP_DSADD = 4'd10,
    OP_CALL  = 4'd11
  } opcodeT;

  // Instruction layout:
  //   [15:12] opcode
  //   [11:8]  rd
  //   [7:4]   rs1
  //   [3:0]   rs2
  //   [7:0]   immediate, shared with rs1 and rs2

endpackage
